// ==== logic/e1000_defs.svh ====
`ifndef E1000_DEFS_SVH
`define E1000_DEFS_SVH

// Register port
`define REG_DATA_W 32
`define REG_ADDR_W 32
`define REG_OFF_W 16

// CTRL
`define CTRL_RST_BIT 26
`define CTRL_PHY_RST_BIT 31

// Full duplex in bit 0, 1000 Mb/s in bits 7:6
`define STATUS_VALUE 32'h0000_0081

// MDIC flag bits
`define MDIC_R_BIT 28
`define MDIC_I_BIT 29

// Interrupt causes
`define ICR_MDAC_BIT 9
`define ICR_PHYINT_BIT 12

`define PHY_SYNC_STAGES 2

// MDIO master
`define MDC_HALF 2   // aclk cycles per MDC half period
`define MDIO_PREAMBLE 32
`define MDIO_FRAME 64
`define PHY_ADDR 5'd1

`endif

// ==== logic/e1000_pkg.sv ====
`include "e1000_defs.svh"

package e1000_pkg;

	// Register offsets, low 16 address bits
	typedef enum logic [`REG_OFF_W-1:0] {
		REG_CTRL   = 16'h0000,
		REG_STATUS = 16'h0008,
		REG_MDIC   = 16'h0020,
		REG_ICR    = 16'h00C0,
		REG_ICS    = 16'h00C8,
		REG_IMS    = 16'h00D0,
		REG_IMC    = 16'h00D8
	} reg_off_e;

	// Clause-22 opcodes
	typedef enum logic [1:0] {
		MDIO_OP_WR = 2'b01,
		MDIO_OP_RD = 2'b10
	} mdio_op_e;

	typedef enum logic [1:0] {
		MDIO_IDLE,
		MDIO_PRE,
		MDIO_SHIFT,
		MDIO_DONE
	} mdio_state_e;

	typedef struct packed {
		logic [`REG_ADDR_W-1:0]   awaddr;
		logic                     awvalid;
		logic [`REG_DATA_W-1:0]   wdata;
		logic [`REG_DATA_W/8-1:0] wstrb;
		logic                     wvalid;
		logic                     bready;
		logic [`REG_ADDR_W-1:0]   araddr;
		logic                     arvalid;
		logic                     rready;
	} axil_req_t;

	typedef struct packed {
		logic                   awready;
		logic                   wready;
		logic [1:0]             bresp;
		logic                   bvalid;
		logic                   arready;
		logic [`REG_DATA_W-1:0] rdata;
		logic [1:0]             rresp;
		logic                   rvalid;
	} axil_rsp_t;

	typedef struct packed {
		mdio_op_e    op;
		logic [4:0]  reg_addr;
		logic [15:0] wdata;
	} mdio_cmd_t;

	// One strobe at a time, data is the written word
	typedef struct packed {
		logic                   ics;
		logic                   ims;
		logic                   imc;
		logic                   icr_rd;
		logic [`REG_DATA_W-1:0] data;
	} intr_wr_t;

endpackage

// ==== logic/e1000_regs.sv ====
`timescale 1ns/1ps
`include "e1000_defs.svh"

module e1000_regs (
	input  logic                   aclk,
	input  logic                   arst_n_i,
	input  e1000_pkg::axil_req_t   axil_req_i,
	output e1000_pkg::axil_rsp_t   axil_rsp_o,
	output logic                   mdio_start_o,
	output e1000_pkg::mdio_cmd_t   mdio_cmd_o,
	input  logic                   mdio_done_i,
	input  logic [15:0]            mdio_rdata_i,
	output e1000_pkg::intr_wr_t    intr_wr_o,
	output logic                   mdac_o,
	input  logic [`REG_DATA_W-1:0] icr_i,
	input  logic [`REG_DATA_W-1:0] ims_i,
	output logic                   reset_request_o,
	output logic                   phy_reset_o
);
	import e1000_pkg::*;

	logic                   aw_ready_q;   // awready and wready together
	logic                   b_valid_q;
	logic                   ar_ready_q;
	logic                   r_valid_q;
	logic [`REG_DATA_W-1:0] r_data_q;
	logic [`REG_DATA_W-1:0] ctrl_q;
	logic [`REG_DATA_W-1:0] mdic_q;
	logic                   mdio_busy_q;
	logic                   mdio_start_q;
	logic                   wr_go;
	logic                   rd_go;
	logic                   mdic_wr;
	reg_off_e               wr_off;
	reg_off_e               rd_off;
	logic [`REG_DATA_W-1:0] rd_mux;

	assign wr_off = reg_off_e'(axil_req_i.awaddr[`REG_OFF_W-1:0]);
	assign rd_off = reg_off_e'(axil_req_i.araddr[`REG_OFF_W-1:0]);

	// Single write outstanding, stalled while bvalid waits
	assign wr_go = axil_req_i.awvalid && axil_req_i.wvalid && !aw_ready_q && !b_valid_q;
	// Read yields to a write accept so the interrupt strobes never overlap
	assign rd_go = axil_req_i.arvalid && !ar_ready_q && !r_valid_q && !wr_go;

	always_ff @(posedge aclk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			aw_ready_q <= 1'b0;
			b_valid_q <= 1'b0;
			ar_ready_q <= 1'b0;
			r_valid_q <= 1'b0;
		end else begin
			aw_ready_q <= wr_go;
			ar_ready_q <= rd_go;
			if (aw_ready_q)
				b_valid_q <= 1'b1;
			else if (axil_req_i.bready)
				b_valid_q <= 1'b0;
			if (ar_ready_q)
				r_valid_q <= 1'b1;
			else if (axil_req_i.rready)
				r_valid_q <= 1'b0;
		end
	end

	always_comb begin
		case (rd_off)
			REG_CTRL:   rd_mux = ctrl_q;
			REG_STATUS: rd_mux = `STATUS_VALUE;
			REG_MDIC:   rd_mux = mdic_q;
			REG_ICR:    rd_mux = icr_i;
			REG_IMS:    rd_mux = ims_i;
			default:    rd_mux = '0;   // ICS, IMC and holes
		endcase
	end

	always_ff @(posedge aclk) begin
		if (ar_ready_q)
			r_data_q <= rd_mux;
	end

	// CTRL honours byte strobes
	always_ff @(posedge aclk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ctrl_q <= '0;
		end else if (aw_ready_q && wr_off == REG_CTRL) begin
			for (int b = 0; b < `REG_DATA_W/8; b++) begin
				if (axil_req_i.wstrb[b])
					ctrl_q[8*b +: 8] <= axil_req_i.wdata[8*b +: 8];
			end
		end
	end

	assign mdic_wr = aw_ready_q && wr_off == REG_MDIC && !mdio_busy_q;

	always_ff @(posedge aclk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			mdic_q <= '0;
			mdio_busy_q <= 1'b0;
			mdio_start_q <= 1'b0;
		end else begin
			mdio_start_q <= mdic_wr;
			if (mdic_wr) begin
				// Keeps I, data, reg, phy and op; R cleared
				mdic_q <= {2'b00, axil_req_i.wdata[`MDIC_I_BIT], 1'b0, axil_req_i.wdata[27:0]};
				mdio_busy_q <= 1'b1;
			end else if (mdio_done_i) begin
				mdic_q[`MDIC_R_BIT] <= 1'b1;
				mdio_busy_q <= 1'b0;
				if (mdio_cmd_o.op == MDIO_OP_RD)
					mdic_q[15:0] <= mdio_rdata_i;
			end
		end
	end

	assign mdio_start_o = mdio_start_q;
	assign mdac_o = mdio_done_i && mdic_q[`MDIC_I_BIT];

	always_comb begin
		mdio_cmd_o.op = mdio_op_e'(mdic_q[27:26]);
		mdio_cmd_o.reg_addr = mdic_q[20:16];
		mdio_cmd_o.wdata = mdic_q[15:0];
	end

	always_comb begin
		intr_wr_o.ics = aw_ready_q && wr_off == REG_ICS;
		intr_wr_o.ims = aw_ready_q && wr_off == REG_IMS;
		intr_wr_o.imc = aw_ready_q && wr_off == REG_IMC;
		intr_wr_o.icr_rd = ar_ready_q && rd_off == REG_ICR;
		intr_wr_o.data = axil_req_i.wdata;
	end

	always_comb begin
		axil_rsp_o.awready = aw_ready_q;
		axil_rsp_o.wready = aw_ready_q;
		axil_rsp_o.bresp = 2'b00;   // OKAY
		axil_rsp_o.bvalid = b_valid_q;
		axil_rsp_o.arready = ar_ready_q;
		axil_rsp_o.rdata = r_data_q;
		axil_rsp_o.rresp = 2'b00;
		axil_rsp_o.rvalid = r_valid_q;
	end

	assign reset_request_o = ctrl_q[`CTRL_RST_BIT];
	assign phy_reset_o = ctrl_q[`CTRL_PHY_RST_BIT] || !arst_n_i;

endmodule

// ==== logic/e1000_intr.sv ====
`timescale 1ns/1ps
`include "e1000_defs.svh"

module e1000_intr (
	input  logic                   aclk,
	input  logic                   arst_n_i,
	input  e1000_pkg::intr_wr_t    intr_wr_i,
	input  logic                   mdac_i,
	input  logic                   phy_int_i,
	output logic [`REG_DATA_W-1:0] icr_o,
	output logic [`REG_DATA_W-1:0] ims_o,
	output logic                   intr_request_o
);

	logic [`PHY_SYNC_STAGES-1:0] phy_sync_q;
	logic                        phy_int_s;
	logic [`REG_DATA_W-1:0]      icr_q;
	logic [`REG_DATA_W-1:0]      ims_q;
	logic [`REG_DATA_W-1:0]      icr_set;
	logic [`REG_DATA_W-1:0]      icr_clr;
	logic [`REG_DATA_W-1:0]      ims_set;
	logic [`REG_DATA_W-1:0]      ims_clr;

	assign phy_int_s = phy_sync_q[`PHY_SYNC_STAGES-1];

	always_comb begin
		icr_set = intr_wr_i.ics ? intr_wr_i.data : '0;
		icr_set[`ICR_MDAC_BIT] = icr_set[`ICR_MDAC_BIT] | mdac_i;
		icr_set[`ICR_PHYINT_BIT] = icr_set[`ICR_PHYINT_BIT] | phy_int_s;   // level, not edge
	end

	assign icr_clr = {`REG_DATA_W{intr_wr_i.icr_rd}};
	assign ims_set = intr_wr_i.ims ? intr_wr_i.data : '0;
	assign ims_clr = intr_wr_i.imc ? intr_wr_i.data : '0;

	always_ff @(posedge aclk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			phy_sync_q <= '0;
			icr_q <= '0;
			ims_q <= '0;
			intr_request_o <= 1'b0;
		end else begin
			phy_sync_q <= {phy_sync_q[`PHY_SYNC_STAGES-2:0], phy_int_i};
			// A new cause beats the read clear
			icr_q <= (icr_q & ~icr_clr) | icr_set;
			ims_q <= (ims_q & ~ims_clr) | ims_set;
			intr_request_o <= |(icr_q & ims_q);
		end
	end

	assign icr_o = icr_q;
	assign ims_o = ims_q;

endmodule

// ==== logic/e1000_mdio.sv ====
`timescale 1ns/1ps
`include "e1000_defs.svh"

module e1000_mdio (
	input  logic                 aclk,
	input  logic                 arst_n_i,
	input  logic                 start_i,
	input  e1000_pkg::mdio_cmd_t cmd_i,
	output logic                 mdc_o,
	input  logic                 mdio_i,
	output logic                 mdio_o,
	output logic                 mdio_oe_o,
	output logic                 done_o,
	output logic [15:0]          rdata_o
);
	import e1000_pkg::*;

	localparam int HALF_W = $clog2(`MDC_HALF);
	localparam int BIT_W = $clog2(`MDIO_FRAME);
	localparam int BODY_W = `MDIO_FRAME - `MDIO_PREAMBLE;
	// Frame positions of turnaround and first data bit
	localparam int TA_BIT = `MDIO_PREAMBLE + 14;
	localparam int DATA_BIT = `MDIO_PREAMBLE + 16;

	mdio_state_e       state_q;
	logic [HALF_W-1:0] half_q;
	logic [BIT_W-1:0]  bit_q;
	logic [BIT_W-1:0]  bit_nxt;
	logic [BODY_W-1:0] body_q;
	logic [15:0]       rd_sh_q;
	logic              rd_op_q;
	logic              active;
	logic              half_end;
	logic              last_bit;
	logic              mdc_rise;
	logic              mdc_fall;
	logic              shift_out;

	assign active = state_q == MDIO_PRE || state_q == MDIO_SHIFT;
	assign half_end = half_q == HALF_W'(`MDC_HALF - 1);
	assign last_bit = bit_q == BIT_W'(`MDIO_FRAME - 1);
	assign bit_nxt = bit_q + 1'b1;
	assign mdc_rise = active && half_end && !mdc_o;
	assign mdc_fall = active && half_end && mdc_o;
	assign shift_out = mdc_fall && !last_bit && bit_nxt >= BIT_W'(`MDIO_PREAMBLE);

	// Last falling edge of the frame
	assign done_o = mdc_fall && last_bit;
	assign rdata_o = rd_sh_q;

	always_ff @(posedge aclk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= MDIO_IDLE;
			half_q <= '0;
			bit_q <= '0;
			mdc_o <= 1'b0;
			mdio_o <= 1'b1;
			mdio_oe_o <= 1'b0;
			rd_op_q <= 1'b0;
		end else begin
			case (state_q)
				MDIO_IDLE: begin
					if (start_i) begin
						state_q <= MDIO_PRE;
						half_q <= '0;
						bit_q <= '0;
						mdio_o <= 1'b1;   // preamble ones
						mdio_oe_o <= 1'b1;
						rd_op_q <= cmd_i.op == MDIO_OP_RD;
					end
				end
				MDIO_PRE, MDIO_SHIFT: begin
					half_q <= half_end ? '0 : half_q + 1'b1;
					if (half_end)
						mdc_o <= !mdc_o;
					if (done_o) begin
						state_q <= MDIO_DONE;
						mdio_o <= 1'b1;
						mdio_oe_o <= 1'b0;
					end else if (mdc_fall) begin
						bit_q <= bit_nxt;
						if (shift_out) begin
							state_q <= MDIO_SHIFT;
							mdio_o <= body_q[BODY_W-1];
						end
						// PHY owns the line from turnaround on
						if (rd_op_q && bit_nxt >= BIT_W'(TA_BIT))
							mdio_oe_o <= 1'b0;
					end
				end
				MDIO_DONE: state_q <= MDIO_IDLE;
				default: state_q <= MDIO_IDLE;
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (state_q == MDIO_IDLE && start_i)
			body_q <= {2'b01, cmd_i.op, `PHY_ADDR, cmd_i.reg_addr, 2'b10, cmd_i.wdata};
		else if (shift_out)
			body_q <= {body_q[BODY_W-2:0], 1'b0};
	end

	// Sample data bits on rising MDC, MSB first
	always_ff @(posedge aclk) begin
		if (mdc_rise && rd_op_q && bit_q >= BIT_W'(DATA_BIT))
			rd_sh_q <= {rd_sh_q[14:0], mdio_i};
	end

endmodule

// ==== logic/e1000_top.sv ====
`timescale 1ns/1ps
`include "e1000_defs.svh"

module e1000_top (
	input  logic                 aclk,
	input  logic                 arst_n_i,
	input  e1000_pkg::axil_req_t s_axil_req_i,
	output e1000_pkg::axil_rsp_t s_axil_rsp_o,
	output logic                 phy_mdc_o,
	input  logic                 phy_mdio_i,
	output logic                 phy_mdio_o,
	output logic                 phy_mdio_oe_o,
	input  logic                 phy_int_i,
	output logic                 intr_request_o,
	output logic                 reset_request_o,
	output logic                 phy_reset_o
);
	import e1000_pkg::*;

	logic                   mdio_start;
	mdio_cmd_t              mdio_cmd;
	logic                   mdio_done;
	logic [15:0]            mdio_rdata;
	intr_wr_t               intr_wr;
	logic                   mdac;
	logic [`REG_DATA_W-1:0] icr;
	logic [`REG_DATA_W-1:0] ims;

	e1000_regs i_regs (
		.aclk            (aclk),
		.arst_n_i        (arst_n_i),
		.axil_req_i      (s_axil_req_i),
		.axil_rsp_o      (s_axil_rsp_o),
		.mdio_start_o    (mdio_start),
		.mdio_cmd_o      (mdio_cmd),
		.mdio_done_i     (mdio_done),
		.mdio_rdata_i    (mdio_rdata),
		.intr_wr_o       (intr_wr),
		.mdac_o          (mdac),
		.icr_i           (icr),
		.ims_i           (ims),
		.reset_request_o (reset_request_o),
		.phy_reset_o     (phy_reset_o)
	);

	e1000_intr i_intr (
		.aclk           (aclk),
		.arst_n_i       (arst_n_i),
		.intr_wr_i      (intr_wr),
		.mdac_i         (mdac),
		.phy_int_i      (phy_int_i),
		.icr_o          (icr),
		.ims_o          (ims),
		.intr_request_o (intr_request_o)
	);

	e1000_mdio i_mdio (
		.aclk      (aclk),
		.arst_n_i  (arst_n_i),
		.start_i   (mdio_start),
		.cmd_i     (mdio_cmd),
		.mdc_o     (phy_mdc_o),
		.mdio_i    (phy_mdio_i),
		.mdio_o    (phy_mdio_o),
		.mdio_oe_o (phy_mdio_oe_o),
		.done_o    (mdio_done),
		.rdata_o   (mdio_rdata)
	);

endmodule

// ==== sim/e1000_assert.sv ====
`timescale 1ns/1ps
`include "e1000_defs.svh"

module e1000_assert (
	input logic                 aclk,
	input logic                 arst_n_i,
	input e1000_pkg::axil_req_t s_axil_req_i,
	input e1000_pkg::axil_rsp_t s_axil_rsp_o,
	input logic                 phy_mdc_o,
	input logic                 phy_mdio_oe_o
);

	logic [3:0] oe_low_cnt;   // MDC low samples while the line is driven

	always_ff @(posedge aclk or negedge arst_n_i) begin
		if (!arst_n_i)
			oe_low_cnt <= '0;
		else if (phy_mdc_o || !phy_mdio_oe_o)
			oe_low_cnt <= '0;
		else if (oe_low_cnt != '1)
			oe_low_cnt <= oe_low_cnt + 1'b1;
	end

	bvalid_hold: assert property (@(posedge aclk) disable iff (!arst_n_i)
		s_axil_rsp_o.bvalid && !s_axil_req_i.bready |=> s_axil_rsp_o.bvalid)
	else $error("bvalid dropped before bready");

	rvalid_hold: assert property (@(posedge aclk) disable iff (!arst_n_i)
		s_axil_rsp_o.rvalid && !s_axil_req_i.rready
		|=> s_axil_rsp_o.rvalid && $stable(s_axil_rsp_o.rdata))
	else $error("rvalid or rdata changed before rready");

	// MDC low past a half period means no frame, so the line is released
	mdio_release: assert property (@(posedge aclk) disable iff (!arst_n_i)
		oe_low_cnt <= 4'(`MDC_HALF))
	else $error("MDIO driven while MDC was idle");

endmodule

bind e1000_top e1000_assert i_assert (
	.aclk          (aclk),
	.arst_n_i      (arst_n_i),
	.s_axil_req_i  (s_axil_req_i),
	.s_axil_rsp_o  (s_axil_rsp_o),
	.phy_mdc_o     (phy_mdc_o),
	.phy_mdio_oe_o (phy_mdio_oe_o)
);

// ==== sim/e1000_tb.sv ====
`timescale 1ns/1ps
`include "e1000_defs.svh"

module e1000_tb;
	import e1000_pkg::*;

	localparam int N_CTRL = 16;
	localparam int N_INTR = 40;
	localparam int N_MDIO = 6;
	// Each MDIO access counts as four bus operations
	localparam int N_OPS = 3 * N_CTRL + N_INTR + 12 + 4 * (2 * N_MDIO + 1);

	logic        aclk;
	logic        arst_n_i;
	axil_req_t   req;
	axil_rsp_t   rsp;
	logic        phy_mdc;
	logic        mdio_to_dut;
	logic        mdio_from_dut;
	logic        mdio_oe;
	logic        phy_int;
	logic        intr_req;
	logic        rst_req;
	logic        phy_rst;
	logic [31:0] ctrl_m;
	logic [31:0] icr_m;
	logic [31:0] ims_m;
	logic [15:0] exp_phy [32];
	logic [15:0] phy_regs [32];   // PHY model contents
	logic [63:0] frame;
	logic        mdc_prev;
	logic        oe_exp;
	int          bit_cnt;
	int          frames_done;
	mdio_op_e    exp_frame_op;
	logic [4:0]  exp_frame_reg;

	e1000_top i_e1000_top (
		.aclk            (aclk),
		.arst_n_i        (arst_n_i),
		.s_axil_req_i    (req),
		.s_axil_rsp_o    (rsp),
		.phy_mdc_o       (phy_mdc),
		.phy_mdio_i      (mdio_to_dut),
		.phy_mdio_o      (mdio_from_dut),
		.phy_mdio_oe_o   (mdio_oe),
		.phy_int_i       (phy_int),
		.intr_request_o  (intr_req),
		.reset_request_o (rst_req),
		.phy_reset_o     (phy_rst)
	);

	initial aclk = 1'b0;
	always #20 aclk = ~aclk;

	task automatic fail_run(input string line);
		$display("%s", line);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else fail_run($sformatf("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp));
	endtask

	function automatic logic [15:0] phy_fill(input logic [4:0] ra);
		return {3'b101, ra, ~ra, 3'b010};
	endfunction

	task automatic idle(input int n);
		repeat (n) @(negedge aclk);
	endtask

	// Starts and ends just after a falling edge
	task automatic bus_write(input logic [15:0] off, input logic [31:0] data,
			input logic [3:0] strb);
		req.awaddr = {16'h0, off};
		req.awvalid = 1'b1;
		req.wdata = data;
		req.wstrb = strb;
		req.wvalid = 1'b1;
		@(negedge aclk);
		while (!rsp.awready)
			@(negedge aclk);
		check_eq("WREADY", 32'(rsp.wready), 32'h1);
		@(negedge aclk);   // handshake edge passed
		req.awvalid = 1'b0;
		req.wvalid = 1'b0;
		check_eq("AWREADY/WREADY after handshake", 32'({rsp.awready, rsp.wready}), 32'h0);
		while (!rsp.bvalid)
			@(negedge aclk);
		check_eq("BRESP", 32'(rsp.bresp), 32'h0);
		idle(int'($urandom % 3) + 1);   // BREADY held back
		req.bready = 1'b1;
		@(negedge aclk);
		req.bready = 1'b0;
	endtask

	task automatic bus_read(input logic [15:0] off, output logic [31:0] data);
		req.araddr = {16'h0, off};
		req.arvalid = 1'b1;
		@(negedge aclk);
		while (!rsp.arready)
			@(negedge aclk);
		@(negedge aclk);
		req.arvalid = 1'b0;
		check_eq("ARREADY after handshake", 32'(rsp.arready), 32'h0);
		while (!rsp.rvalid)
			@(negedge aclk);
		idle(int'($urandom % 3) + 1);   // RREADY held back
		data = rsp.rdata;
		check_eq("RRESP", 32'(rsp.rresp), 32'h0);
		req.rready = 1'b1;
		@(negedge aclk);
		req.rready = 1'b0;
	endtask

	task automatic read_check(input logic [15:0] off, input logic [31:0] exp, input string what);
		logic [31:0] got;
		bus_read(off, got);
		check_eq(what, got, exp);
	endtask

	task automatic mdio_run(input mdio_op_e op, input logic [4:0] ra, input logic [15:0] wd,
			input logic ien);
		logic [4:0]  phy_f;
		logic [15:0] data_f;
		logic [31:0] mdic;
		int          polls;
		int          frames_before;
		phy_f = 5'($urandom);   // frames still carry the fixed PHY address
		frames_before = frames_done;
		exp_frame_op = op;
		exp_frame_reg = ra;
		bus_write(REG_MDIC, {2'b00, ien, 1'b0, op, phy_f, ra, wd}, 4'hF);
		polls = 0;
		mdic = '0;
		while (!mdic[`MDIC_R_BIT] && polls < 200) begin
			bus_read(REG_MDIC, mdic);
			polls++;
		end
		assert (mdic[`MDIC_R_BIT])
		else fail_run("MDIC ready bit never came up after an MDIO access");
		if (op == MDIO_OP_WR)
			exp_phy[ra] = wd;
		data_f = op == MDIO_OP_RD ? exp_phy[ra] : wd;
		check_eq("MDIC", mdic, {2'b00, ien, 1'b1, op, phy_f, ra, data_f});
		check_eq("PHY register", 32'(phy_regs[ra]), 32'(exp_phy[ra]));
		check_eq("MDIO frame count", frames_done, frames_before + 1);
		if (ien)
			icr_m[`ICR_MDAC_BIT] = 1'b1;
		read_check(REG_ICR, icr_m, "ICR after MDIO access");
		icr_m = '0;
	endtask

	// PHY side of the MDIO bus
	initial begin
		for (int i = 0; i < 32; i++)
			phy_regs[5'(i)] = phy_fill(5'(i));
		mdio_to_dut = 1'b1;
		mdc_prev = 1'b0;
		bit_cnt = 0;
		frames_done = 0;
		frame = '0;
		forever begin
			@(negedge aclk);
			if (phy_mdc && !mdc_prev) begin
				// Line is released from turnaround on for reads
				oe_exp = bit_cnt < 46 || frame[29:28] != MDIO_OP_RD;
				assert (mdio_oe == oe_exp)
				else fail_run($sformatf("ERR %0t ns: MDIO enable %b at frame bit %0d",
					$time, mdio_oe, bit_cnt));
				frame[6'(63 - bit_cnt)] = mdio_from_dut;
				bit_cnt++;
				if (bit_cnt == `MDIO_FRAME) begin
					assert (frame[63:32] == '1 && frame[31:30] == 2'b01
						&& frame[29:28] == exp_frame_op && frame[27:23] == `PHY_ADDR
						&& frame[22:18] == exp_frame_reg)
					else fail_run($sformatf("ERR %0t ns: bad MDIO frame %h", $time, frame));
					if (frame[29:28] == MDIO_OP_WR) begin
						check_eq("MDIO turnaround", 32'(frame[17:16]), 32'h2);
						phy_regs[frame[22:18]] = frame[15:0];
					end
					frames_done++;
					bit_cnt = 0;
				end
			end else if (!phy_mdc && mdc_prev) begin
				if (bit_cnt >= 48 && frame[29:28] == MDIO_OP_RD)
					mdio_to_dut = phy_regs[frame[22:18]][4'(63 - bit_cnt)];
				else
					mdio_to_dut = 1'b1;
			end
			mdc_prev = phy_mdc;
		end
	end

	initial begin
		repeat (N_OPS * 300) @(posedge aclk);
		fail_run("Timeout: the watchdog expired before the tests finished");
	end

	initial begin
		logic [31:0] data;
		logic [31:0] mask;
		logic [3:0]  strb;
		logic [4:0]  ra;
		int          cnt;
		void'($urandom(39));
		req = '0;
		arst_n_i = 1'b0;
		phy_int = 1'b0;
		ctrl_m = '0;
		icr_m = '0;
		ims_m = '0;
		for (int i = 0; i < 32; i++)
			exp_phy[5'(i)] = phy_fill(5'(i));
		@(negedge aclk);
		assert (phy_rst && !intr_req && !rst_req && !mdio_oe && !phy_mdc && mdio_from_dut
			&& !rsp.awready && !rsp.wready && !rsp.bvalid && !rsp.arready && !rsp.rvalid)
		else fail_run("Outputs were not at their reset values during reset");
		repeat (2) @(negedge aclk);
		arst_n_i = 1'b1;
		idle(2);

		// CTRL and STATUS
		for (int n = 0; n < N_CTRL; n++) begin
			data = $urandom;
			strb = 4'($urandom);
			bus_write(REG_CTRL, data, strb);
			mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
			ctrl_m = (ctrl_m & ~mask) | (data & mask);
			read_check(REG_CTRL, ctrl_m, "CTRL");
			check_eq("reset_request_o", 32'(rst_req), 32'(ctrl_m[`CTRL_RST_BIT]));
			check_eq("phy_reset_o", 32'(phy_rst), 32'(ctrl_m[`CTRL_PHY_RST_BIT]));
			read_check(REG_STATUS, `STATUS_VALUE, "STATUS");
		end
		bus_write(REG_CTRL, '0, 4'hF);
		ctrl_m = '0;
		read_check(16'h0100, '0, "unmapped offset");

		// Interrupt registers
		for (int n = 0; n < N_INTR; n++) begin
			data = $urandom;
			case ($urandom % 5)
				0: begin
					bus_write(REG_ICS, data, 4'hF);
					icr_m = icr_m | data;
				end
				1: begin
					bus_write(REG_IMS, data, 4'hF);
					ims_m = ims_m | data;
				end
				2: begin
					bus_write(REG_IMC, data, 4'hF);
					ims_m = ims_m & ~data;
				end
				3: begin
					read_check(REG_ICR, icr_m, "ICR");
					icr_m = '0;   // cleared by the read
				end
				default: read_check(REG_IMS, ims_m, "IMS");
			endcase
			idle(2);
			check_eq("intr_request_o", 32'(intr_req), 32'(|(icr_m & ims_m)));
		end

		// PHY interrupt, only its cause unmasked
		bus_write(REG_IMC, '1, 4'hF);
		ims_m = 32'h1 << `ICR_PHYINT_BIT;
		bus_write(REG_IMS, ims_m, 4'hF);
		read_check(REG_ICR, icr_m, "ICR");
		icr_m = '0;
		phy_int = 1'b1;
		cnt = 0;
		while (!intr_req && cnt < 6) begin
			@(negedge aclk);
			cnt++;
		end
		assert (intr_req)
		else fail_run("PHY interrupt did not reach intr_request_o within 6 cycles");
		icr_m = 32'h1 << `ICR_PHYINT_BIT;
		read_check(REG_ICR, icr_m, "ICR with PHY interrupt");
		phy_int = 1'b0;
		idle(4);
		read_check(REG_ICR, icr_m, "ICR after PHY interrupt drop");
		icr_m = '0;
		read_check(REG_ICR, icr_m, "ICR after clear");
		idle(2);
		check_eq("intr_request_o", 32'(intr_req), 32'h0);

		// MDIO writes and reads
		ra = '0;
		for (int n = 0; n < N_MDIO; n++) begin
			ra = 5'($urandom);
			mdio_run(MDIO_OP_WR, ra, 16'($urandom), 1'($urandom));
			mdio_run(MDIO_OP_RD, 5'($urandom), 16'($urandom), 1'($urandom));
		end
		mdio_run(MDIO_OP_RD, ra, 16'($urandom), 1'b1);   // last written register

		idle(4);
		$display("Test completed successfully");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+logic
logic/e1000_pkg.sv
logic/e1000_regs.sv
logic/e1000_intr.sv
logic/e1000_mdio.sv
logic/e1000_top.sv
sim/e1000_assert.sv
sim/e1000_tb.sv

// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only +incdir+logic logic/e1000_pkg.sv logic/e1000_regs.sv \
		logic/e1000_intr.sv logic/e1000_mdio.sv logic/e1000_top.sv --top-module e1000_top
	verilator --lint-only --timing --assert -f all.f --top-module e1000_tb

sim:
	verilator --binary --timing --assert -f all.f --top-module e1000_tb \
		-Mdir obj_dir -o e1000_sim
	./obj_dir/e1000_sim | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
